// ==== bench/rv_decode_patterns.hex ====
// instr _ pc _ compressed _ pc_next _ imm_i _ imm_j _ alu_res _ res_src _ op2_src _ reg_write
// _ supported _ csr {write,set,clear,read}; alu_res {cmp,bits,shift,arith}; op2 {r,i,j}
00500093_00001000_0_00001004_00000005_00000800_0_1_2_1_1_0
002081B3_00001004_1_00001006_00000002_00000802_1_1_4_1_1_0
40208233_00001006_0_0000100A_00000402_00000404_1_1_4_1_1_0
0080A283_0000100A_0_0000100E_00000008_00000804_1_4_2_1_1_0
0020A623_0000100E_0_00001012_0000000C_0000000C_1_1_2_0_1_0
12345337_00001012_1_00001014_12345000_00000126_0_1_2_1_1_0
00001397_00001014_0_00001018_00001000_00000806_0_1_2_1_1_0
00208863_00001018_0_0000101C_00000002_00000010_8_1_4_0_1_0
008000EF_0000101C_0_00001020_00000008_00000008_0_2_1_1_1_0
00008067_00001020_0_00001024_00000000_00000000_0_2_2_1_1_0
0000A087_00001024_0_00001028_00000000_00000800_0_1_4_1_0_0
00000000_00001028_1_0000102A_00000000_00000000_0_0_0_0_0_0
00000073_0000102A_0_0000102E_00000000_00000000_0_1_4_1_1_0
00100073_0000102E_0_00001032_00000001_00000000_0_1_4_1_1_0
30200073_00001032_0_00001036_00000302_00000300_0_1_4_1_1_0
300092F3_00001036_0_0000103A_00000300_00000B04_0_1_4_1_1_9
30512373_0000103A_0_0000103E_00000305_00000306_0_1_4_1_1_5
3001B073_0000103E_0_00001042_00000300_00000300_0_1_4_1_1_3
02208433_00001042_0_00001046_00000022_00000028_0_1_4_1_1_0
4030D493_00001046_0_0000104A_00000403_00000C08_2_1_2_1_1_0
0020A533_0000104A_0_0000104E_00000002_0000000A_8_1_4_1_1_0
FFF0C593_0000104E_1_00001050_FFFFFFFF_FFFFFFEA_4_1_2_1_1_0

// ==== tb.f ====
+incdir+hw
hw/rv_decode_pkg.sv
hw/rv_decode_latch.sv
hw/rv_decode_classify.sv
hw/rv_decode_control.sv
hw/rv_decode_top.sv
bench/tb_rv_decode.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f tb.f \
		--top-module tb_rv_decode -Mdir obj_dir -o sim_tb

run: compile
	./obj_dir/sim_tb | tee sim.log
	grep -q "^Verification passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/tb_rv_decode.sv ====
`timescale 1ns/1ps

module tb_rv_decode;

    import rv_decode_pkg::*;

    localparam int NPAT = 22;

    logic        i_clk;
    logic        i_reset;
    logic        i_ready;
    logic        i_flush;
    logic        i_stall;
    logic        i_branch_pred;
    logic        i_is_compressed;
    rv_instr_t   i_instruction;
    rv_addr_t    i_pc;
    rv_dec_t     o_dec;
    rv_csr_req_t o_csr;
    logic        o_valid;

    logic [187:0] pats [0:NPAT-1];
    int           exp_idx[$];
    int           exp_edge[$];
    int           exp_stalls[$];
    int           edge_n;
    int           stall_n;
    int           checks;
    int           errors;
    int           tests;
    int           failed_tests;
    int           test_err_start;
    string        cur_test;
    integer       seed;
    rv_dec_t      prev_dec;
    logic         prev_valid;

    rv_decode_top i_dut
    (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_instruction   (i_instruction),
        .i_ready         (i_ready),
        .i_flush         (i_flush),
        .i_stall         (i_stall),
        .i_pc            (i_pc),
        .i_branch_pred   (i_branch_pred),
        .i_is_compressed (i_is_compressed),
        .o_dec           (o_dec),
        .o_csr           (o_csr),
        .o_valid         (o_valid)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    task automatic check_field(input string field, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (exp === act)
        else
        begin
            errors++;
            $display("[FAIL] %s %s: expected %h, actual %h", cur_test, field, exp, act);
        end
    endtask

    // a bubble is supported, funct3 010, all else zero
    task automatic check_bubble(input string field);
        rv_dec_t exp_dec;
        exp_dec                = '0;
        exp_dec.funct3         = 3'b010;
        exp_dec.inst_supported = 1'b1;
        checks++;
        assert (o_dec === exp_dec)
        else
        begin
            errors++;
            $display("[FAIL] %s %s: expected %h, actual %h", cur_test, field, exp_dec, o_dec);
        end
    endtask

    task automatic compare_word();
        int           idx;
        int           lat;
        logic [187:0] p;
        rv_instr_t    ins;
        logic [4:0]   exp_rs1;
        string        tag;
        idx = exp_idx.pop_front();
        lat = (edge_n - exp_edge.pop_front()) - (stall_n - exp_stalls.pop_front());
        p   = pats[idx];
        ins = p[187:156];
        // lui carries no rs1
        exp_rs1 = (ins[6:0] == 7'b0110111) ? 5'd0 : ins[19:15];
        tag = $sformatf("pattern %0d", idx);
        check_field({tag, " latency"}, 3, lat);
        check_field({tag, " pc"}, p[155:124], o_dec.pc);
        check_field({tag, " pc_next"}, p[119:88], o_dec.pc_next);
        check_field({tag, " imm_i"}, p[87:56], o_dec.imm_i);
        check_field({tag, " imm_j"}, p[55:24], o_dec.imm_j);
        check_field({tag, " alu_res"}, p[23:20], o_dec.alu_res);
        check_field({tag, " res_src"}, p[18:16], o_dec.res_src);
        check_field({tag, " op2_src"}, p[14:12], o_dec.op2_src);
        check_field({tag, " reg_write"}, p[8], o_dec.reg_write);
        check_field({tag, " supported"}, p[4], o_dec.inst_supported);
        check_field({tag, " csr strobes"}, p[3:0],
                    {o_csr.write, o_csr.set, o_csr.clear, o_csr.read});
        check_field({tag, " rd"}, ins[11:7], o_dec.rd);
        check_field({tag, " rs1"}, exp_rs1, o_dec.rs1);
        check_field({tag, " rs2"}, ins[24:20], o_dec.rs2);
        check_field({tag, " branch_pred"}, idx[0], o_dec.branch_pred);
        if (p[0])
        begin
            check_field({tag, " csr idx"}, ins[31:20], o_csr.idx);
        end
    endtask

    task automatic check_outputs();
        logic [3:0] strobes;
        strobes = {o_csr.write, o_csr.set, o_csr.clear, o_csr.read};
        if (i_reset)
        begin
            check_field("reset o_valid", 0, o_valid);
            check_bubble("reset o_dec");
            check_field("reset csr strobes", 0, strobes);
        end
        else if (i_stall)
        begin
            checks++;
            assert (o_dec === prev_dec && o_valid === prev_valid)
            else
            begin
                errors++;
                $display("%s: decode output changed while the pipe was stalled", cur_test);
            end
            check_field("stall csr write/set/clear", 0, strobes[3:1]);
        end
        else if (o_valid)
        begin
            checks++;
            assert (exp_idx.size() > 0)
            else
            begin
                errors++;
                $display("%s: o_valid high with no accepted word in flight", cur_test);
            end
            if (exp_idx.size() > 0)
            begin
                compare_word();
            end
        end
        else
        begin
            check_bubble("idle o_dec");
            check_field("idle csr strobes", 0, strobes);
        end
        prev_dec   = o_dec;
        prev_valid = o_valid;
    endtask

    // sample just after the edge, before new inputs go out
    task automatic tick();
        @(posedge i_clk);
        #10;
        edge_n++;
        if (i_stall)
        begin
            stall_n++;
        end
        check_outputs();
    endtask

    task automatic drive_word(input int idx, input logic rdy, input logic fl, input logic st);
        logic [187:0] p;
        p               = pats[idx];
        i_instruction   = p[187:156];
        i_pc            = p[155:124];
        i_is_compressed = p[120];
        // a rejected word carries a prediction that must not show up
        i_branch_pred   = (rdy && !fl) ? idx[0] : 1'b1;
        i_ready         = rdy;
        i_flush         = fl;
        i_stall         = st;
        if (fl)
        begin
            // everything in flight turns into bubbles
            exp_idx.delete();
            exp_edge.delete();
            exp_stalls.delete();
        end
        else if (rdy && !st)
        begin
            exp_idx.push_back(idx);
            exp_edge.push_back(edge_n);
            exp_stalls.push_back(stall_n);
        end
    endtask

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    task automatic issue(input int idx);
        drive_word(idx, 1'b1, 1'b0, 1'b0);
        tick();
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (exp_idx.size() > 0 && n < 20)
        begin
            drive_word(0, 1'b0, 1'b0, 1'b0);
            tick();
            n++;
        end
        checks++;
        assert (exp_idx.size() == 0)
        else
        begin
            errors++;
            $display("%s: timeout, %0d words never came out", cur_test, exp_idx.size());
        end
    endtask

    task automatic start_test(input string name);
        cur_test       = name;
        test_err_start = errors;
    endtask

    task automatic end_test();
        tests++;
        if (errors > test_err_start)
        begin
            failed_tests++;
            $display("test %s: %0d errors", cur_test, errors - test_err_start);
        end
        else
        begin
            $display("test %s: ok", cur_test);
        end
    endtask

    initial
    begin
        int gap;
        i_reset         = 1'b1;
        i_ready         = 1'b0;
        i_flush         = 1'b0;
        i_stall         = 1'b0;
        i_branch_pred   = 1'b0;
        i_is_compressed = 1'b0;
        i_instruction   = '0;
        i_pc            = '0;
        seed            = 32'h63b8_937f;
        edge_n          = 0;
        stall_n         = 0;
        checks          = 0;
        errors          = 0;
        tests           = 0;
        failed_tests    = 0;
        prev_dec        = '0;
        prev_valid      = 1'b0;
        $readmemh("bench/rv_decode_patterns.hex", pats);

        start_test("reset");
        repeat (8) tick();
        i_reset = 1'b0;
        repeat (4)
        begin
            drive_word(0, 1'b0, 1'b0, 1'b0);
            tick();
        end
        end_test();

        start_test("decode");
        for (int i = 0; i < NPAT; i++)
        begin
            issue(i);
        end
        drain();
        end_test();

        start_test("ready_gaps");
        for (int i = 0; i < NPAT; i++)
        begin
            gap = rand_below(3);
            for (int g = 0; g < gap; g++)
            begin
                drive_word(rand_below(NPAT), 1'b0, 1'b0, 1'b0);
                tick();
            end
            issue(i);
        end
        drain();
        end_test();

        start_test("stall");
        for (int i = 0; i < NPAT; i++)
        begin
            // also stall while a CSR write, set or clear sits at the output
            if (rand_below(3) == 0 || (i >= 3 && pats[i-3][3:1] != 3'b000))
            begin
                gap = 1 + rand_below(3);
                for (int g = 0; g < gap; g++)
                begin
                    drive_word(rand_below(NPAT), 1'b0, 1'b0, 1'b1);
                    tick();
                end
            end
            issue(i);
        end
        drain();
        end_test();

        start_test("flush");
        for (int i = 0; i < NPAT; i++)
        begin
            if (i % 5 == 4)
            begin
                drive_word(i, 1'b1, 1'b1, 1'b0);
                tick();
            end
            else
            begin
                issue(i);
            end
        end
        drain();
        end_test();

        $display("tests: %0d, failed: %0d, checks: %0d, errors: %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0)
        begin
            $display("Verification passed");
        end
        else
        begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== hw/rv_decode_top.sv ====
`timescale 1ns/1ps

module rv_decode_top
(
    input  logic                       i_clk,
    input  logic                       i_reset,
    input  rv_decode_pkg::rv_instr_t   i_instruction,
    input  logic                       i_ready,
    input  logic                       i_flush,
    input  logic                       i_stall,
    input  rv_decode_pkg::rv_addr_t    i_pc,
    input  logic                       i_branch_pred,
    input  logic                       i_is_compressed,
    output rv_decode_pkg::rv_dec_t     o_dec,
    output rv_decode_pkg::rv_csr_req_t o_csr,
    output logic                       o_valid
);

    import rv_decode_pkg::*;

    rv_fetch_t fetch;
    rv_class_t cls;

    rv_decode_latch u_latch
    (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_stall         (i_stall),
        .i_flush         (i_flush),
        .i_ready         (i_ready),
        .i_instruction   (i_instruction),
        .i_pc            (i_pc),
        .i_branch_pred   (i_branch_pred),
        .i_is_compressed (i_is_compressed),
        .o_fetch         (fetch)
    );

    rv_decode_classify u_classify
    (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_stall (i_stall),
        .i_flush (i_flush),
        .i_fetch (fetch),
        .o_class (cls)
    );

    rv_decode_control u_control
    (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_stall (i_stall),
        .i_flush (i_flush),
        .i_class (cls),
        .o_dec   (o_dec),
        .o_csr   (o_csr),
        .o_valid (o_valid)
    );

endmodule

// ==== hw/rv_decode_control.sv ====
`timescale 1ns/1ps

`include "rv_decode_consts.svh"

module rv_decode_control
(
    input  logic                       i_clk,
    input  logic                       i_reset,
    input  logic                       i_stall,
    input  logic                       i_flush,
    input  rv_decode_pkg::rv_class_t   i_class,
    output rv_decode_pkg::rv_dec_t     o_dec,
    output rv_decode_pkg::rv_csr_req_t o_csr,
    output logic                       o_valid
);

    import rv_decode_pkg::*;

    rv_funct3_t  f3;
    logic        int_grp;
    logic        upper_or_mem;
    logic        mul_sub3;
    logic        mul_sub4;
    rv_alu_sub_t alu_sub;
    rv_dec_t     dec;
    rv_csr_req_t csr;
    rv_csr_req_t csr_q;

    assign f3           = i_class.funct3;
    assign int_grp      = i_class.ari | i_class.arr;
    assign upper_or_mem = i_class.lui | i_class.auipc | i_class.jal |
                          i_class.load | i_class.store;

    // M group sub-code bits
    assign mul_sub3 = (f3[2] & !f3[0]) | (!f3[2] & !f3[1] & f3[0]);
    assign mul_sub4 = (f3[2] & !f3[0]) | (!f3[2] & (f3[1] ^ f3[0]));

    always_comb
    begin
        alu_sub[2:0] = upper_or_mem ? 3'b000 : f3;
        alu_sub[3]   = (i_class.branch & f3[0]) | (i_class.mul & mul_sub3);
        if (i_class.branch || i_class.sra || i_class.srai ||
            ((int_grp || i_class.mul) && (f3[2:1] == 2'b01)))
        begin
            alu_sub[4] = 1'b1;
        end
        else if (upper_or_mem || i_class.ari)
        begin
            alu_sub[4] = 1'b0;
        end
        else if (i_class.mul)
        begin
            alu_sub[4] = mul_sub4;
        end
        else
        begin
            alu_sub[4] = i_class.funct7[5];
        end
        alu_sub[5]   = i_class.mul;
    end

    always_comb
    begin
        dec.pc      = i_class.fetch.pc;
        dec.pc_next = i_class.fetch.pc_next;
        dec.rd      = i_class.rd;
        dec.rs1     = i_class.lui ? '0 : i_class.rs1;
        dec.rs2     = i_class.rs2;
        dec.imm_i   = i_class.imm_i;
        dec.imm_j   = i_class.imm_j;
        dec.funct3  = i_class.full ? f3 : 3'b010;
        dec.alu_sub = alu_sub;

        dec.alu_res.cmp   = i_class.branch | (int_grp & (f3[2:1] == 2'b01));
        dec.alu_res.bits  = int_grp & f3[2] & (f3[1:0] != 2'b01);
        dec.alu_res.shift = int_grp & (f3[1:0] == 2'b01);
        dec.alu_res.arith = (i_class.arr & (f3 == 3'b000)) | i_class.load | i_class.store;

        dec.res_src.memory  = i_class.load;
        dec.res_src.pc_next = i_class.jalr | i_class.jal;
        dec.res_src.alu     = i_class.full & !(i_class.load | i_class.jalr | i_class.jal);

        dec.reg_write = i_class.full & !(i_class.branch | i_class.store);
        dec.op1_src   = i_class.auipc | i_class.jal;

        dec.op2_src.j = i_class.jal;
        dec.op2_src.i = i_class.jalr | i_class.load | i_class.ari | i_class.lui |
                        i_class.auipc | i_class.store;
        dec.op2_src.r = i_class.full & !(dec.op2_src.i | i_class.jal);

        dec.inst_mret    = i_class.mret;
        dec.inst_jalr    = i_class.jalr;
        dec.inst_jal     = i_class.jal;
        dec.inst_branch  = i_class.branch;
        dec.inst_store   = i_class.store;
        dec.inst_csr_req = i_class.csr_req;

        // bubbles count as supported
        dec.inst_supported = !i_class.fetch.valid |
                             i_class.load | i_class.arr | i_class.mul | i_class.auipc |
                             i_class.store | i_class.ari | i_class.lui | i_class.branch |
                             i_class.jalr | i_class.jal | i_class.ecall | i_class.ebreak |
                             i_class.csr_req | (i_class.mret & `RV_EXT_ZICSR);
        dec.branch_pred    = i_class.fetch.branch_pred;
    end

    always_comb
    begin
        csr.idx     = i_class.fetch.instr[31:20];
        csr.imm     = i_class.rs1;
        csr.imm_sel = f3[2];
        csr.write   = i_class.csr_req & (f3[1:0] == 2'b01);
        csr.set     = i_class.csr_req & (f3[1:0] == 2'b10);
        csr.clear   = i_class.csr_req & (f3[1:0] == 2'b11);
        csr.read    = i_class.csr_req;
        csr.ebreak  = i_class.ebreak;
    end

    always_ff @(posedge i_clk)
    begin
        if (i_reset || i_flush)
        begin
            o_valid              <= 1'b0;
            // bubble is supported, with funct3 010
            o_dec                <= '0;
            o_dec.funct3         <= 3'b010;
            o_dec.inst_supported <= 1'b1;
            csr_q                <= '0;
        end
        else if (!i_stall)
        begin
            o_valid <= i_class.fetch.valid;
            o_dec   <= dec;
            csr_q   <= csr;
        end
    end

    // side-effect strobes must not repeat while the pipe is frozen
    always_comb
    begin
        o_csr       = csr_q;
        o_csr.write = csr_q.write & !i_stall;
        o_csr.set   = csr_q.set & !i_stall;
        o_csr.clear = csr_q.clear & !i_stall;
    end

endmodule

// ==== hw/rv_decode_classify.sv ====
`timescale 1ns/1ps

`include "rv_decode_consts.svh"

module rv_decode_classify
(
    input  logic                     i_clk,
    input  logic                     i_reset,
    input  logic                     i_stall,
    input  logic                     i_flush,
    input  rv_decode_pkg::rv_fetch_t i_fetch,
    output rv_decode_pkg::rv_class_t o_class
);

    import rv_decode_pkg::*;

    rv_instr_t           instr;
    logic [4:0]          opc;
    rv_funct3_t          funct3;
    logic [6:0]          funct7;
    logic [11:0]         funct12;
    logic                full;
    logic                sys_f3_zero;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_s;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] imm_j;
    rv_class_t           cls;

    assign instr   = i_fetch.instr;
    assign opc     = instr[6:2];
    assign funct3  = instr[14:12];
    assign funct7  = instr[31:25];
    assign funct12 = instr[31:20];
    assign full    = (instr[1:0] == `RV_OPC_FULL);

    assign imm_i = { {21{instr[31]}}, instr[30:20] };
    assign imm_s = { {21{instr[31]}}, instr[30:25], instr[11:7] };
    assign imm_b = { {20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0 };
    assign imm_u = { instr[31:12], 12'b0 };
    assign imm_j = { {12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0 };

    always_comb
    begin
        cls        = '0;
        cls.fetch  = i_fetch;
        cls.rd     = instr[11:7];
        cls.rs1    = instr[19:15];
        cls.rs2    = instr[24:20];
        cls.funct3 = funct3;
        cls.funct7 = funct7;
        cls.full   = full;

        cls.load   = full & (opc == `RV_OPC_LOAD);
        cls.ari    = full & (opc == `RV_OPC_OP_IMM);
        cls.auipc  = full & (opc == `RV_OPC_AUIPC);
        cls.store  = full & (opc == `RV_OPC_STORE);
        cls.lui    = full & (opc == `RV_OPC_LUI);
        cls.branch = full & (opc == `RV_OPC_BRANCH);
        cls.jalr   = full & (opc == `RV_OPC_JALR) & (funct3 == 3'b000);
        cls.jal    = full & (opc == `RV_OPC_JAL);
        cls.sys    = full & (opc == `RV_OPC_SYSTEM);

        // funct7[0] splits the OP space into base and M
        cls.arr    = full & (opc == `RV_OPC_OP) & !funct7[0];
        cls.mul    = full & (opc == `RV_OPC_OP) & funct7[0] & `RV_EXT_M;

        cls.ecall   = cls.sys & sys_f3_zero & (funct12 == 12'h000);
        cls.ebreak  = cls.sys & sys_f3_zero & (funct12 == 12'h001);
        cls.mret    = cls.sys & sys_f3_zero & (funct12 == 12'h302);
        cls.csr_req = cls.sys & !sys_f3_zero & `RV_EXT_ZICSR;

        // arithmetic right shifts
        cls.srai = cls.ari & (funct3 == 3'b101) & funct7[5];
        cls.sra  = cls.arr & (funct3 == 3'b101) & funct7[5];

        if (cls.lui || cls.auipc)
        begin
            cls.imm_i = imm_u;
        end
        else if (cls.store)
        begin
            cls.imm_i = imm_s;
        end
        else
        begin
            cls.imm_i = imm_i;
        end

        cls.imm_j = cls.jal ? imm_j : imm_b;
    end

    assign sys_f3_zero = (funct3 == 3'b000);

    always_ff @(posedge i_clk)
    begin
        if (i_reset || i_flush)
        begin
            o_class <= '0;
        end
        else if (!i_stall)
        begin
            o_class <= cls;
        end
    end

endmodule

// ==== hw/rv_decode_latch.sv ====
`timescale 1ns/1ps

module rv_decode_latch
(
    input  logic                     i_clk,
    input  logic                     i_reset,
    input  logic                     i_stall,
    input  logic                     i_flush,
    input  logic                     i_ready,
    input  rv_decode_pkg::rv_instr_t i_instruction,
    input  rv_decode_pkg::rv_addr_t  i_pc,
    input  logic                     i_branch_pred,
    input  logic                     i_is_compressed,
    output rv_decode_pkg::rv_fetch_t o_fetch
);

    import rv_decode_pkg::*;

    logic      accept;
    rv_addr_t  pc_step;
    rv_fetch_t fetch;

    assign accept  = i_ready & !i_flush;

    // 2 for a compressed word, 4 otherwise
    assign pc_step = i_is_compressed ? rv_addr_t'(2) : rv_addr_t'(4);

    always_comb
    begin
        fetch = '0;
        if (accept)
        begin
            fetch.valid       = 1'b1;
            fetch.instr       = i_instruction;
            fetch.pc          = i_pc;
            fetch.pc_next     = i_pc + pc_step;
            fetch.branch_pred = i_branch_pred;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_reset || i_flush)
        begin
            o_fetch <= '0;
        end
        else if (!i_stall)
        begin
            o_fetch <= fetch;
        end
    end

endmodule

// ==== hw/rv_decode_pkg.sv ====
`include "rv_decode_consts.svh"

package rv_decode_pkg;

    typedef logic [`RV_XLEN-1:0]       rv_instr_t;
    typedef logic [`RV_IADDR_BITS-1:0] rv_addr_t;
    typedef logic [4:0]                rv_reg_idx_t;
    typedef logic [2:0]                rv_funct3_t;
    typedef logic [5:0]                rv_alu_sub_t;
    typedef logic [11:0]               rv_csr_idx_t;

    // one-hot ALU result class
    typedef struct packed {
        logic cmp;
        logic bits;
        logic shift;
        logic arith;
    } alu_res_t;

    typedef struct packed {
        logic memory;
        logic pc_next;
        logic alu;
    } res_src_t;

    typedef struct packed {
        logic r;
        logic i;
        logic j;
    } src_op2_t;

    // stage 1 output
    typedef struct packed {
        logic      valid;
        rv_instr_t instr;
        rv_addr_t  pc;
        rv_addr_t  pc_next;
        logic      branch_pred;
    } rv_fetch_t;

    // stage 2 output
    typedef struct packed {
        rv_fetch_t           fetch;
        rv_reg_idx_t         rd;
        rv_reg_idx_t         rs1;
        rv_reg_idx_t         rs2;
        rv_funct3_t          funct3;
        logic [6:0]          funct7;
        logic                full;
        logic                load;
        logic                ari;
        logic                arr;
        logic                mul;
        logic                auipc;
        logic                lui;
        logic                store;
        logic                branch;
        logic                jalr;
        logic                jal;
        logic                sys;
        logic                ecall;
        logic                ebreak;
        logic                mret;
        logic                csr_req;
        logic                srai;
        logic                sra;
        logic [`RV_XLEN-1:0] imm_i;
        logic [`RV_XLEN-1:0] imm_j;
    } rv_class_t;

    typedef struct packed {
        rv_addr_t            pc;
        rv_addr_t            pc_next;
        rv_reg_idx_t         rd;
        rv_reg_idx_t         rs1;
        rv_reg_idx_t         rs2;
        logic [`RV_XLEN-1:0] imm_i;
        logic [`RV_XLEN-1:0] imm_j;
        rv_funct3_t          funct3;
        rv_alu_sub_t         alu_sub;
        alu_res_t            alu_res;
        res_src_t            res_src;
        logic                reg_write;
        logic                op1_src;
        src_op2_t            op2_src;
        logic                inst_mret;
        logic                inst_jalr;
        logic                inst_jal;
        logic                inst_branch;
        logic                inst_store;
        logic                inst_csr_req;
        logic                inst_supported;
        logic                branch_pred;
    } rv_dec_t;

    typedef struct packed {
        rv_csr_idx_t idx;
        rv_reg_idx_t imm;
        logic        imm_sel;
        logic        write;
        logic        set;
        logic        clear;
        logic        read;
        logic        ebreak;
    } rv_csr_req_t;

endpackage

// ==== hw/rv_decode_consts.svh ====
`ifndef RV_DECODE_CONSTS_SVH
`define RV_DECODE_CONSTS_SVH

// data and instruction width
`define RV_XLEN                 32

// program counter width
`define RV_IADDR_BITS           32

// major opcode, bits 6..2
`define RV_OPC_LOAD             5'b00000
`define RV_OPC_OP_IMM           5'b00100
`define RV_OPC_AUIPC            5'b00101
`define RV_OPC_STORE            5'b01000
`define RV_OPC_OP               5'b01100
`define RV_OPC_LUI              5'b01101
`define RV_OPC_BRANCH           5'b11000
`define RV_OPC_JALR             5'b11001
`define RV_OPC_JAL              5'b11011
`define RV_OPC_SYSTEM           5'b11100

// low opcode bits of a full-size word
`define RV_OPC_FULL             2'b11

// extension enables
`define RV_EXT_M                1'b1
`define RV_EXT_ZICSR            1'b1

`endif
